/* lpif_link_pkg.sv */
////////////////////////////////////////
// LPIF logical link package
// Link word layout, sizes and enums
////////////////////////////////////////
`default_nettype none

package lpif_link_pkg;

  // Flit field widths
  localparam int STATE_W  = 4;
  localparam int PROTID_W = 2;
  localparam int DATA_W   = 64;
  localparam int CRC_W    = 16;

  // One link word carries one flit plus its valid bit
  localparam int LINK_W   = 89;

  // Receive buffer size and initial credits
  localparam int BUF_DEPTH = 8;
  localparam int CRED_W    = $clog2(BUF_DEPTH + 1);
  localparam int PTR_W     = $clog2(BUF_DEPTH);

  // Online delay value width
  localparam int DELAY_W   = 16;

  ////////////////////////////////////////
  // Link word field offsets
  localparam int STATE_LSB  = 0;
  localparam int PROTID_LSB = STATE_LSB + STATE_W;
  localparam int DATA_LSB   = PROTID_LSB + PROTID_W;
  localparam int DVALID_LSB = DATA_LSB + DATA_W;
  localparam int CRC_LSB    = DVALID_LSB + 1;
  localparam int CRCV_LSB   = CRC_LSB + CRC_W;
  // Top bit marks a live flit
  localparam int VALID_LSB  = CRCV_LSB + 1;

  ////////////////////////////////////////
  // Producer link control
  typedef enum logic [1:0] {
    LINK_OFFLINE = 2'd0,
    LINK_DELAY   = 2'd1,
    LINK_ONLINE  = 2'd2
  } link_state_e;

  // Protocol id of a flit
  typedef enum logic [PROTID_W-1:0] {
    PROT_IO    = 2'd0,
    PROT_CACHE = 2'd1,
    PROT_MEM   = 2'd2,
    PROT_RSVD  = 2'd3
  } protid_e;

endpackage

`default_nettype wire

/* lpif_ustrm_pack.sv */
////////////////////////////////////////
// LPIF upstream producer
// Online delay, credits and flit packing
////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module lpif_ustrm_pack (
  input  logic                                clk_wr,
  input  logic                                arst_n,
  // Link control
  input  logic                                tx_online,
  input  logic [lpif_link_pkg::DELAY_W-1:0]   delay_value,
  // Upstream channel
  input  logic                                ustrm_valid,
  output logic                                ustrm_ready,
  input  logic [lpif_link_pkg::STATE_W-1:0]   ustrm_state,
  input  lpif_link_pkg::protid_e              ustrm_protid,
  input  logic [lpif_link_pkg::DATA_W-1:0]    ustrm_data,
  input  logic                                ustrm_dvalid,
  input  logic [lpif_link_pkg::CRC_W-1:0]     ustrm_crc,
  input  logic                                ustrm_crc_valid,
  // Link side
  output logic [lpif_link_pkg::LINK_W-1:0]    link_word,
  output logic                                link_valid,
  input  logic                                credit_return,
  // Debug
  output logic [31:0]                         tx_flit_count
);

  import lpif_link_pkg::*;

  link_state_e          state;
  logic [DELAY_W-1:0]   delay_cnt;
  logic [CRED_W-1:0]    credit_cnt;
  logic                 accept;
  logic [LINK_W-1:0]    link_nxt;

  ////////////////////////////////////////
  // Online delay FSM

  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      state     <= LINK_OFFLINE;
      delay_cnt <= '0;
    end else if (!tx_online) begin
      // Any drop of tx_online takes the link down
      state     <= LINK_OFFLINE;
      delay_cnt <= '0;
    end else begin
      case (state)
        LINK_OFFLINE: begin
          state     <= LINK_DELAY;
          delay_cnt <= '0;
        end
        LINK_DELAY: begin
          // Leave after delay_value cycles in this state
          if (delay_cnt == delay_value) begin
            state <= LINK_ONLINE;
          end else begin
            delay_cnt <= delay_cnt + 1'b1;
          end
        end
        default: state <= LINK_ONLINE;
      endcase
    end
  end

  ////////////////////////////////////////
  // Credits and handshake

  // Ready only when online with room downstream
  assign ustrm_ready = (state == LINK_ONLINE) && (credit_cnt != '0);
  assign accept      = ustrm_valid && ustrm_ready;

  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      credit_cnt <= CRED_W'(BUF_DEPTH);
    end else begin
      case ({accept, credit_return})
        2'b10:   credit_cnt <= credit_cnt - 1'b1;
        2'b01:   credit_cnt <= credit_cnt + 1'b1;
        // Spend and return together cancel out
        default: credit_cnt <= credit_cnt;
      endcase
    end
  end

  ////////////////////////////////////////
  // Flit packing

  always_comb begin
    link_nxt                            = '0;
    link_nxt[STATE_LSB  +: STATE_W]     = ustrm_state;
    link_nxt[PROTID_LSB +: PROTID_W]    = ustrm_protid;
    link_nxt[DATA_LSB   +: DATA_W]      = ustrm_data;
    link_nxt[DVALID_LSB]                = ustrm_dvalid;
    link_nxt[CRC_LSB    +: CRC_W]       = ustrm_crc;
    link_nxt[CRCV_LSB]                  = ustrm_crc_valid;
    link_nxt[VALID_LSB]                 = 1'b1;
  end

  // Payload register
  always_ff @(posedge clk_wr) begin
    if (accept) begin
      link_word <= link_nxt;
    end
  end

  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      link_valid    <= 1'b0;
      tx_flit_count <= '0;
    end else begin
      link_valid <= accept;
      // Sent flits
      if (link_valid) begin
        tx_flit_count <= tx_flit_count + 1'b1;
      end
    end
  end

  ////////////////////////////////////////
  // Checks

  // Buffer must never hand back more credits than it owns
  a_credit_max: assert property (@(posedge clk_wr) disable iff (!arst_n)
    credit_cnt <= CRED_W'(BUF_DEPTH));

  // Every word on the link was paid for a cycle earlier
  a_valid_credit: assert property (@(posedge clk_wr) disable iff (!arst_n)
    link_valid |-> $past(credit_cnt != '0));

endmodule

`default_nettype wire

/* lpif_rx_buffer.sv */
////////////////////////////////////////
// LPIF receive buffer
// Link word FIFO with credit return
////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module lpif_rx_buffer (
  input  logic                              clk_wr,
  input  logic                              arst_n,
  // From producer
  input  logic [lpif_link_pkg::LINK_W-1:0]  link_word,
  input  logic                              link_valid,
  output logic                              credit_return,
  // To consumer
  output logic [lpif_link_pkg::LINK_W-1:0]  buf_word,
  output logic                              buf_empty,
  input  logic                              buf_pop
);

  import lpif_link_pkg::*;

  // Storage
  logic [LINK_W-1:0]  mem [BUF_DEPTH];

  logic [PTR_W-1:0]   wr_ptr;
  logic [PTR_W-1:0]   rd_ptr;
  // Occupancy 0 to BUF_DEPTH
  logic [CRED_W-1:0]  count;
  logic               full;

  assign buf_empty = (count == '0);
  assign full      = (count == CRED_W'(BUF_DEPTH));
  // Head entry
  assign buf_word  = mem[rd_ptr];

  ////////////////////////////////////////
  // Write side

  always_ff @(posedge clk_wr) begin
    if (link_valid) begin
      mem[wr_ptr] <= link_word;
    end
  end

  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
    end else if (link_valid) begin
      if (wr_ptr == PTR_W'(BUF_DEPTH - 1)) begin
        wr_ptr <= '0;
      end else begin
        wr_ptr <= wr_ptr + 1'b1;
      end
    end
  end

  ////////////////////////////////////////
  // Read side and occupancy

  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      rd_ptr <= '0;
    end else if (buf_pop) begin
      if (rd_ptr == PTR_W'(BUF_DEPTH - 1)) begin
        rd_ptr <= '0;
      end else begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      count         <= '0;
      credit_return <= 1'b0;
    end else begin
      case ({link_valid, buf_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      // One credit per released entry
      credit_return <= buf_pop;
    end
  end

  ////////////////////////////////////////
  // Checks

  // A write into a full buffer means the producer broke credit rules
  a_no_overflow: assert property (@(posedge clk_wr) disable iff (!arst_n)
    link_valid |-> !full);

  a_no_underflow: assert property (@(posedge clk_wr) disable iff (!arst_n)
    buf_pop |-> !buf_empty);

endmodule

`default_nettype wire

/* lpif_dstrm_unpack.sv */
////////////////////////////////////////
// LPIF downstream consumer
// Pops buffer and drives flit fields
////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module lpif_dstrm_unpack (
  input  logic                              clk_wr,
  input  logic                              arst_n,
  // Buffer side
  input  logic [lpif_link_pkg::LINK_W-1:0]  buf_word,
  input  logic                              buf_empty,
  output logic                              buf_pop,
  // Downstream channel
  output logic                              dstrm_valid,
  input  logic                              dstrm_ready,
  output logic [lpif_link_pkg::STATE_W-1:0] dstrm_state,
  output lpif_link_pkg::protid_e            dstrm_protid,
  output logic [lpif_link_pkg::DATA_W-1:0]  dstrm_data,
  output logic                              dstrm_dvalid,
  output logic [lpif_link_pkg::CRC_W-1:0]   dstrm_crc,
  output logic                              dstrm_crc_valid,
  // Debug
  output logic [31:0]                       rx_flit_count
);

  import lpif_link_pkg::*;

  // Held output flit
  logic [LINK_W-1:0]  out_word;
  logic               out_free;

  ////////////////////////////////////////
  // Pop decision

  // Register empty or about to drain
  assign out_free = !dstrm_valid || dstrm_ready;
  assign buf_pop  = out_free && !buf_empty;

  always_ff @(posedge clk_wr) begin
    if (buf_pop) begin
      out_word <= buf_word;
    end
  end

  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      dstrm_valid   <= 1'b0;
      rx_flit_count <= '0;
    end else begin
      if (buf_pop) begin
        dstrm_valid <= 1'b1;
      end else if (dstrm_ready) begin
        dstrm_valid <= 1'b0;
      end
      // Delivered flits
      if (dstrm_valid && dstrm_ready) begin
        rx_flit_count <= rx_flit_count + 1'b1;
      end
    end
  end

  ////////////////////////////////////////
  // Field split

  assign dstrm_state     = out_word[STATE_LSB +: STATE_W];
  assign dstrm_protid    = protid_e'(out_word[PROTID_LSB +: PROTID_W]);
  assign dstrm_data      = out_word[DATA_LSB +: DATA_W];
  assign dstrm_dvalid    = out_word[DVALID_LSB];
  assign dstrm_crc       = out_word[CRC_LSB +: CRC_W];
  assign dstrm_crc_valid = out_word[CRCV_LSB];

  ////////////////////////////////////////
  // Checks

  // Flit stays put until taken
  a_hold: assert property (@(posedge clk_wr) disable iff (!arst_n)
    dstrm_valid && !dstrm_ready |=> dstrm_valid && $stable(out_word));

  // Every popped entry was written by the producer
  a_live_word: assert property (@(posedge clk_wr) disable iff (!arst_n)
    buf_pop |-> buf_word[VALID_LSB]);

endmodule

`default_nettype wire

/* lpif_link_top.sv */
////////////////////////////////////////
// LPIF single lane logical link
// Producer, receive buffer and consumer
////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module lpif_link_top (
  input  logic                              clk_wr,
  input  logic                              arst_n,
  // Control
  input  logic                              tx_online,
  input  logic [lpif_link_pkg::DELAY_W-1:0] delay_value,
  // Upstream channel
  input  logic                              ustrm_valid,
  output logic                              ustrm_ready,
  input  logic [lpif_link_pkg::STATE_W-1:0] ustrm_state,
  input  lpif_link_pkg::protid_e            ustrm_protid,
  input  logic [lpif_link_pkg::DATA_W-1:0]  ustrm_data,
  input  logic                              ustrm_dvalid,
  input  logic [lpif_link_pkg::CRC_W-1:0]   ustrm_crc,
  input  logic                              ustrm_crc_valid,
  // Downstream channel
  output logic                              dstrm_valid,
  input  logic                              dstrm_ready,
  output logic [lpif_link_pkg::STATE_W-1:0] dstrm_state,
  output lpif_link_pkg::protid_e            dstrm_protid,
  output logic [lpif_link_pkg::DATA_W-1:0]  dstrm_data,
  output logic                              dstrm_dvalid,
  output logic [lpif_link_pkg::CRC_W-1:0]   dstrm_crc,
  output logic                              dstrm_crc_valid,
  // Debug status
  output logic [31:0]                       tx_upstream_debug_status,
  output logic [31:0]                       rx_downstream_debug_status
);

  import lpif_link_pkg::*;

  ////////////////////////////////////////
  // Internal link wires
  logic [LINK_W-1:0]  link_word;
  logic               link_valid;
  logic               credit_return;
  logic [LINK_W-1:0]  buf_word;
  logic               buf_empty;
  logic               buf_pop;

  ////////////////////////////////////////
  // Transmit side
  lpif_ustrm_pack u_ustrm_pack (
    .clk_wr          (clk_wr),
    .arst_n          (arst_n),
    .tx_online       (tx_online),
    .delay_value     (delay_value),
    .ustrm_valid     (ustrm_valid),
    .ustrm_ready     (ustrm_ready),
    .ustrm_state     (ustrm_state),
    .ustrm_protid    (ustrm_protid),
    .ustrm_data      (ustrm_data),
    .ustrm_dvalid    (ustrm_dvalid),
    .ustrm_crc       (ustrm_crc),
    .ustrm_crc_valid (ustrm_crc_valid),
    .link_word       (link_word),
    .link_valid      (link_valid),
    .credit_return   (credit_return),
    .tx_flit_count   (tx_upstream_debug_status)
  );

  // Receive buffer
  lpif_rx_buffer u_rx_buffer (
    .clk_wr        (clk_wr),
    .arst_n        (arst_n),
    .link_word     (link_word),
    .link_valid    (link_valid),
    .credit_return (credit_return),
    .buf_word      (buf_word),
    .buf_empty     (buf_empty),
    .buf_pop       (buf_pop)
  );

  // Downstream side
  lpif_dstrm_unpack u_dstrm_unpack (
    .clk_wr          (clk_wr),
    .arst_n          (arst_n),
    .buf_word        (buf_word),
    .buf_empty       (buf_empty),
    .buf_pop         (buf_pop),
    .dstrm_valid     (dstrm_valid),
    .dstrm_ready     (dstrm_ready),
    .dstrm_state     (dstrm_state),
    .dstrm_protid    (dstrm_protid),
    .dstrm_data      (dstrm_data),
    .dstrm_dvalid    (dstrm_dvalid),
    .dstrm_crc       (dstrm_crc),
    .dstrm_crc_valid (dstrm_crc_valid),
    .rx_flit_count   (rx_downstream_debug_status)
  );

endmodule

`default_nettype wire

/* tb_clock_gen.sv */
////////////////////////////////////////
// Testbench clock source with a 4 ns period
////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen (
  output logic clk
);

  // Half of the 4 ns period
  localparam int HALF_PERIOD = 2;

  initial clk = 1'b0;

  always #HALF_PERIOD clk = ~clk;

endmodule

`default_nettype wire

/* tb_lpif_link.sv */
////////////////////////////////////////
// LPIF link testbench
// Random flits checked against a queue model
////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module tb_lpif_link;

  import lpif_link_pkg::*;

  // Run length
  localparam int RESET_CYCLES = 5;
  localparam int ONLINE_DELAY = 10;
  localparam int N_RANDOM     = 300;
  localparam int STALL_CYCLES = 16;
  localparam int TOTAL_FLITS  = N_RANDOM + BUF_DEPTH + 1;
  localparam int TOTAL_DELAY  = RESET_CYCLES + ONLINE_DELAY + 1 + STALL_CYCLES;
  localparam int CYCLE_LIMIT  = 20 * (TOTAL_FLITS + TOTAL_DELAY);

  typedef struct packed {
    logic [STATE_W-1:0] state;
    protid_e            protid;
    logic [DATA_W-1:0]  data;
    logic               dvalid;
    logic [CRC_W-1:0]   crc;
    logic               crc_valid;
  } flit_t;

  // How the downstream user drives dstrm_ready
  typedef enum logic [1:0] {READY_LOW, READY_HIGH, READY_RAND} ready_mode_e;

  logic clk_wr, arst_n, tx_online;
  logic [DELAY_W-1:0] delay_value;
  logic ustrm_valid, ustrm_ready, ustrm_dvalid, ustrm_crc_valid;
  logic [STATE_W-1:0] ustrm_state;
  protid_e ustrm_protid;
  logic [DATA_W-1:0] ustrm_data;
  logic [CRC_W-1:0] ustrm_crc;
  logic dstrm_valid, dstrm_ready, dstrm_dvalid, dstrm_crc_valid;
  logic [STATE_W-1:0] dstrm_state;
  protid_e dstrm_protid;
  logic [DATA_W-1:0] dstrm_data;
  logic [CRC_W-1:0] dstrm_crc;
  logic [31:0] tx_dbg, rx_dbg;

  flit_t       model_q[$];
  ready_mode_e ready_mode;
  logic [3:0]  protid_seen;
  int errors = 0;
  int test_start_errors = 0;
  int tests_passed = 0;
  int tests_failed = 0;
  int accepted_total = 0;
  int cycle_cnt = 0;
  int wait_cycles, taken, rise_wait;

  tb_clock_gen u_clk (.clk(clk_wr));

  lpif_link_top uut (
    .clk_wr (clk_wr), .arst_n (arst_n), .tx_online (tx_online),
    .delay_value (delay_value), .ustrm_valid (ustrm_valid), .ustrm_ready (ustrm_ready),
    .ustrm_state (ustrm_state), .ustrm_protid (ustrm_protid), .ustrm_data (ustrm_data),
    .ustrm_dvalid (ustrm_dvalid), .ustrm_crc (ustrm_crc), .ustrm_crc_valid (ustrm_crc_valid),
    .dstrm_valid (dstrm_valid), .dstrm_ready (dstrm_ready), .dstrm_state (dstrm_state),
    .dstrm_protid (dstrm_protid), .dstrm_data (dstrm_data), .dstrm_dvalid (dstrm_dvalid),
    .dstrm_crc (dstrm_crc), .dstrm_crc_valid (dstrm_crc_valid),
    .tx_upstream_debug_status (tx_dbg), .rx_downstream_debug_status (rx_dbg)
  );

  ////////////////////////////////////////
  // Downstream ready driven 1 ns after the edge
  always @(posedge clk_wr) begin : ready_driver
    logic ready_nxt;
    // Mode and coin flip taken on the edge itself
    case (ready_mode)
      READY_LOW:  ready_nxt = 1'b0;
      READY_HIGH: ready_nxt = 1'b1;
      default:    ready_nxt = ($urandom_range(99, 0) < 70);
    endcase
    #1;
    dstrm_ready = ready_nxt;
  end

  // Run limit
  always @(posedge clk_wr) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("timeout: run stopped after %0d cycles, %0d flits never arrived",
               cycle_cnt, model_q.size());
      $display("tests failed");
      $finish;
    end
  end

  ////////////////////////////////////////
  // Reference model sampled mid cycle
  task automatic check_flit(input flit_t exp);
    assert (dstrm_state == exp.state) else begin
      $display("error at %0t: dstrm_state %h, expected %h", $time, dstrm_state, exp.state);
      errors++;
    end
    assert (dstrm_protid == exp.protid) else begin
      $display("error at %0t: dstrm_protid %h, expected %h", $time, dstrm_protid, exp.protid);
      errors++;
    end
    assert (dstrm_data == exp.data) else begin
      $display("error at %0t: dstrm_data %h, expected %h", $time, dstrm_data, exp.data);
      errors++;
    end
    assert (dstrm_dvalid == exp.dvalid) else begin
      $display("error at %0t: dstrm_dvalid %b, expected %b", $time, dstrm_dvalid, exp.dvalid);
      errors++;
    end
    assert (dstrm_crc == exp.crc) else begin
      $display("error at %0t: dstrm_crc %h, expected %h", $time, dstrm_crc, exp.crc);
      errors++;
    end
    assert (dstrm_crc_valid == exp.crc_valid) else begin
      $display("error at %0t: dstrm_crc_valid %b, expected %b", $time, dstrm_crc_valid,
               exp.crc_valid);
      errors++;
    end
  endtask

  always @(negedge clk_wr) begin : model_monitor
    flit_t acc;
    // Transfer happens on the coming edge
    if (arst_n && ustrm_valid && ustrm_ready) begin
      acc.state     = ustrm_state;
      acc.protid    = ustrm_protid;
      acc.data      = ustrm_data;
      acc.dvalid    = ustrm_dvalid;
      acc.crc       = ustrm_crc;
      acc.crc_valid = ustrm_crc_valid;
      model_q.push_back(acc);
      protid_seen[int'(ustrm_protid)] = 1'b1;
      accepted_total++;
    end
    if (arst_n && dstrm_valid && dstrm_ready) begin
      assert (model_q.size() != 0) else begin
        $display("flit delivered downstream at %0t that was never accepted", $time);
        errors++;
      end
      if (model_q.size() != 0) begin
        check_flit(model_q.pop_front());
      end
    end
  end

  ////////////////////////////////////////
  // Stimulus helpers
  task automatic load_random_flit();
    ustrm_state     = STATE_W'($urandom);
    ustrm_protid    = protid_e'($urandom_range(3, 0));
    ustrm_data      = {$urandom, $urandom};
    ustrm_dvalid    = $urandom_range(1, 0);
    ustrm_crc       = CRC_W'($urandom);
    ustrm_crc_valid = $urandom_range(1, 0);
  endtask

  // Called 1 ns after an edge and returns the same way
  task automatic random_traffic(input int n);
    int  sent;
    logic took;
    sent = 0;
    while (sent < n) begin
      if (!ustrm_valid && ($urandom_range(99, 0) < 60)) begin
        load_random_flit();
        ustrm_valid = 1'b1;
      end
      @(negedge clk_wr);
      took = ustrm_valid && ustrm_ready;
      @(posedge clk_wr);
      #1;
      if (took) begin
        sent++;
        ustrm_valid = 1'b0;
      end
    end
  endtask

  // Valid held high until ready stays low
  task automatic stall_fill(output int count);
    int   low_run;
    logic took;
    count   = 0;
    low_run = 0;
    load_random_flit();
    ustrm_valid = 1'b1;
    while (low_run < STALL_CYCLES) begin
      @(negedge clk_wr);
      took = ustrm_ready;
      @(posedge clk_wr);
      #1;
      if (took) begin
        count++;
        low_run = 0;
        load_random_flit();
      end else begin
        low_run++;
      end
    end
    ustrm_valid = 1'b0;
  endtask

  task automatic wait_drain();
    while (model_q.size() != 0) begin
      @(posedge clk_wr);
      #1;
    end
    // Last delivery edge updates the rx count
    @(posedge clk_wr);
    #1;
  endtask

  task automatic check_reset_outputs(input string phase);
    assert (ustrm_ready == 1'b0 && dstrm_valid == 1'b0) else begin
      $display("error at %0t: %s, ustrm_ready %b dstrm_valid %b", $time, phase,
               ustrm_ready, dstrm_valid);
      errors++;
    end
    assert (tx_dbg == 32'd0 && rx_dbg == 32'd0) else begin
      $display("error at %0t: %s, debug status %0d / %0d", $time, phase, tx_dbg, rx_dbg);
      errors++;
    end
  endtask

  task automatic finish_test(input string name);
    if (errors == test_start_errors) begin
      tests_passed++;
      $display("test %s: pass", name);
    end else begin
      tests_failed++;
      $display("test %s: fail with %0d errors", name, errors - test_start_errors);
    end
    test_start_errors = errors;
  endtask

  ////////////////////////////////////////
  // Test sequence
  initial begin
    void'($urandom(32'hb615_53b0));
    arst_n = 1'b0;
    tx_online = 1'b0;
    delay_value = '0;
    ustrm_valid = 1'b0;
    ustrm_state = '0;
    ustrm_protid = PROT_IO;
    ustrm_data = '0;
    ustrm_dvalid = 1'b0;
    ustrm_crc = '0;
    ustrm_crc_valid = 1'b0;
    dstrm_ready = 1'b0;
    ready_mode = READY_LOW;
    protid_seen = '0;

    // Reset values
    repeat (RESET_CYCLES) begin
      @(negedge clk_wr);
      check_reset_outputs("during reset");
    end
    @(posedge clk_wr);
    #1;
    arst_n = 1'b1;
    @(negedge clk_wr);
    check_reset_outputs("after reset");
    finish_test("reset");

    // Online delay counted from the edge that sees tx_online
    @(posedge clk_wr);
    #1;
    delay_value = DELAY_W'(ONLINE_DELAY);
    tx_online   = 1'b1;
    @(posedge clk_wr);
    wait_cycles = 0;
    do begin
      @(posedge clk_wr);
      #1;
      wait_cycles++;
    end while (!ustrm_ready);
    assert (wait_cycles == ONLINE_DELAY + 1) else begin
      $display("error at %0t: ustrm_ready rose after %0d cycles, expected %0d", $time,
               wait_cycles, ONLINE_DELAY + 1);
      errors++;
    end
    finish_test("online_delay");

    // Random traffic both ways
    ready_mode = READY_RAND;
    random_traffic(N_RANDOM);
    wait_drain();
    assert (protid_seen == 4'b1111) else begin
      $display("not every protocol id was sent, seen mask %b", protid_seen);
      errors++;
    end
    finish_test("data_integrity");

    // Full buffer plus the held flit
    ready_mode = READY_LOW;
    @(posedge clk_wr);
    #1;
    stall_fill(taken);
    assert (taken == BUF_DEPTH + 1) else begin
      $display("error at %0t: %0d flits accepted under stall, expected %0d", $time,
               taken, BUF_DEPTH + 1);
      errors++;
    end
    ready_mode = READY_HIGH;
    wait_drain();
    rise_wait = 0;
    while (!ustrm_ready && rise_wait < 8) begin
      @(posedge clk_wr);
      #1;
      rise_wait++;
    end
    assert (ustrm_ready) else begin
      $display("ustrm_ready stayed low after the buffer drained");
      errors++;
    end
    finish_test("back_pressure");

    // Debug counters against the model
    assert (tx_dbg == accepted_total) else begin
      $display("error at %0t: tx debug %0d, expected %0d", $time, tx_dbg, accepted_total);
      errors++;
    end
    assert (rx_dbg == accepted_total) else begin
      $display("error at %0t: rx debug %0d, expected %0d", $time, rx_dbg, accepted_total);
      errors++;
    end
    finish_test("debug_counts");

    $display("summary: %0d passed, %0d failed, %0d errors", tests_passed, tests_failed,
             errors);
    if (tests_failed == 0 && errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* project.f */
lpif_link_pkg.sv
lpif_ustrm_pack.sv
lpif_rx_buffer.sv
lpif_dstrm_unpack.sv
lpif_link_top.sv
tb_clock_gen.sv
tb_lpif_link.sv

/* Makefile */
# Verilator build, run and lint for the LPIF link

VERILATOR  ?= verilator
TOP        ?= tb_lpif_link
DUT_TOP    ?= lpif_link_top
FILELIST   ?= project.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only -Wall --timing
PASS_MSG   ?= all tests passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# Pass only if the pass line shows up in the output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(DUT_TOP)

clean:
	rm -rf $(OBJ_DIR)
